// File: Bender.yml
package:
  name: mcl_axil_adapter

sources:
  - source/mcl_pkg.sv
  - source/word_stream_if.sv
  - source/mcl_axil_regs.sv
  - source/mcl_tx_packer.sv
  - source/mcl_rx_buffer.sv
  - source/mcl_rx_unpacker.sv
  - source/mcl_axil_adapter.sv
  - target: simulation
    files:
      - sim/tb_mcl_axil_adapter.sv

// File: mcl_axil_adapter.f
source/mcl_pkg.sv
source/word_stream_if.sv
source/mcl_axil_regs.sv
source/mcl_tx_packer.sv
source/mcl_rx_buffer.sv
source/mcl_rx_unpacker.sv
source/mcl_axil_adapter.sv
sim/tb_mcl_axil_adapter.sv

// File: sim/mcl_axil_stim.txt
# op, fields in hex: W addr data resp | R addr data resp | M/T w0 w1 w2 w3, w0 lowest
# V lowest_vacancy final_vacancy | F vacancy_at_stall | B/D count base (burst in, drain)
R 8 1 0
W 0 11111111 0
W 0 22222222 0
W 0 33333333 0
W 0 44444444 0
W 0 a5a50001 0
W 0 a5a50002 0
W 0 a5a50003 0
W 0 a5a50004 0
T 11111111 22222222 33333333 44444444
T a5a50001 a5a50002 a5a50003 a5a50004
R 8 1 0
M cafe0000 cafe0001 cafe0002 cafe0003
V 7 8
R 8 3 0
R 4 cafe0000 0
R 4 cafe0001 0
R 4 cafe0002 0
R 4 cafe0003 0
R 8 1 0
R 4 0 2
W c 12345678 2
W 4 87654321 2
R 10 0 2
R 0 0 2
B a 5a000000
F 0
R 8 3 0
D a 5a000000
V 0 8
R 8 1 0

// File: sim/tb_mcl_axil_adapter.sv
// ----------------------------------------------------------------------
// AXI-lite host tasks, link model and file driven checks for the bridge
// ----------------------------------------------------------------------

module tb_mcl_axil_adapter;

  import mcl_pkg::*;

  localparam int mcl_width_lp = 128;
  localparam int fifo_els_lp  = 8;
  localparam int words_lp     = mcl_width_lp / WORD_W;
  localparam int vac_w_lp     = $clog2(fifo_els_lp + 1);

  typedef logic [mcl_width_lp-1:0] msg_t;
  typedef logic [vac_w_lp-1:0]     vac_t;

  logic       clk_i;
  logic       rst_i;
  axil_addr_t s_axil_awaddr_i;
  logic       s_axil_awvalid_i;
  logic       s_axil_awready_o;
  word_t      s_axil_wdata_i;
  logic       s_axil_wvalid_i;
  logic       s_axil_wready_o;
  axil_resp_t s_axil_bresp_o;
  logic       s_axil_bvalid_o;
  logic       s_axil_bready_i;
  axil_addr_t s_axil_araddr_i;
  logic       s_axil_arvalid_i;
  logic       s_axil_arready_o;
  word_t      s_axil_rdata_o;
  axil_resp_t s_axil_rresp_o;
  logic       s_axil_rvalid_o;
  logic       s_axil_rready_i;
  logic       mcl_v_i;
  msg_t       mcl_data_i;
  logic       mcl_r_o;
  logic       mcl_v_o;
  msg_t       mcl_data_o;
  logic       mcl_r_i;
  vac_t       rcv_vacancy_o;

  // link model state
  msg_t        msg_in_q[$];
  msg_t        msg_out_q[$];
  logic [31:0] lfsr;
  logic        link_take;
  vac_t        min_vac;

  // bookkeeping
  string       lines[$];
  string       step_note;
  int unsigned cycles;
  int unsigned cycle_limit;
  int unsigned checks;
  int unsigned errors;

  mcl_axil_adapter u_mcl_axil_adapter (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .mcl_v_i          (mcl_v_i),
    .mcl_data_i       (mcl_data_i),
    .mcl_r_o          (mcl_r_o),
    .mcl_v_o          (mcl_v_o),
    .mcl_data_o       (mcl_data_o),
    .mcl_r_i          (mcl_r_i),
    .rcv_vacancy_o    (rcv_vacancy_o)
  );

  // 8 time unit period
  always #4 clk_i = ~clk_i;

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // burst word k of message m, distinct per slot
  function automatic word_t pattern_word(input word_t base, input int m, input int k);
    return base + word_t'(m * 256 + k);
  endfunction

  task automatic compare_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // AXI-lite host side
  // ----------------------------------------------------------------------
  task automatic write_reg(input axil_addr_t addr, input word_t data,
                           input axil_resp_t exp_resp);
    axil_resp_t resp;
    @(posedge clk_i);
    s_axil_awaddr_i  <= addr;
    s_axil_wdata_i   <= data;
    s_axil_awvalid_i <= 1'b1;
    s_axil_wvalid_i  <= 1'b1;
    // aw and w ready pulse together after any tx back-pressure
    @(negedge clk_i);
    while (!s_axil_awready_o) @(negedge clk_i);
    compare_value($sformatf("wready with awready for %0h", addr), s_axil_wready_o, 1'b1);
    @(posedge clk_i);
    s_axil_awvalid_i <= 1'b0;
    s_axil_wvalid_i  <= 1'b0;
    @(negedge clk_i);
    while (!s_axil_bvalid_o) @(negedge clk_i);
    // bready one cycle late so bvalid must hold
    @(posedge clk_i);
    s_axil_bready_i <= 1'b1;
    @(negedge clk_i);
    compare_value($sformatf("bvalid held for write to %0h", addr), s_axil_bvalid_o, 1'b1);
    resp = s_axil_bresp_o;
    @(posedge clk_i);
    s_axil_bready_i <= 1'b0;
    compare_value($sformatf("bresp for write to %0h", addr), resp, exp_resp);
  endtask

  task automatic read_reg(input axil_addr_t addr, input word_t exp_data,
                          input axil_resp_t exp_resp);
    word_t      data;
    axil_resp_t resp;
    @(posedge clk_i);
    s_axil_araddr_i  <= addr;
    s_axil_arvalid_i <= 1'b1;
    @(negedge clk_i);
    while (!s_axil_arready_o) @(negedge clk_i);
    @(posedge clk_i);
    s_axil_arvalid_i <= 1'b0;
    @(negedge clk_i);
    while (!s_axil_rvalid_o) @(negedge clk_i);
    // rready one cycle late so rvalid and rdata must hold
    @(posedge clk_i);
    s_axil_rready_i <= 1'b1;
    @(negedge clk_i);
    compare_value($sformatf("rvalid held for read of %0h", addr), s_axil_rvalid_o, 1'b1);
    data = s_axil_rdata_o;
    resp = s_axil_rresp_o;
    @(posedge clk_i);
    s_axil_rready_i <= 1'b0;
    compare_value($sformatf("rdata from %0h", addr), data, exp_data);
    compare_value($sformatf("rresp from %0h", addr), resp, exp_resp);
  endtask

  // ----------------------------------------------------------------------
  // link side helpers
  // ----------------------------------------------------------------------
  task automatic queue_msg(input msg_t msg);
    @(negedge clk_i);
    msg_in_q.push_back(msg);
  endtask

  task automatic inject_burst(input word_t n, input word_t base);
    msg_t msg;
    for (int m = 0; m < n; m++) begin
      for (int k = 0; k < words_lp; k++) begin
        msg[k*WORD_W +: WORD_W] = pattern_word(base, m, k);
      end
      queue_msg(msg);
    end
  endtask

  // every burst word back through REG_RX_DATA in order
  task automatic drain_burst(input word_t n, input word_t base);
    for (int m = 0; m < n; m++) begin
      for (int k = 0; k < words_lp; k++) begin
        read_reg(REG_RX_DATA, pattern_word(base, m, k), RESP_OKAY);
      end
    end
  endtask

  task automatic expect_msg(input msg_t exp);
    msg_t got;
    @(negedge clk_i);
    while (msg_out_q.size() == 0) @(negedge clk_i);
    got = msg_out_q.pop_front();
    compare_value("outgoing message", got, exp);
  endtask

  // lowest credit since the last check once the link is idle
  task automatic settled_vacancy(input word_t lo, input word_t fin);
    @(negedge clk_i);
    while (msg_in_q.size() != 0 || mcl_v_i || rcv_vacancy_o != fin) @(negedge clk_i);
    compare_value("lowest rcv_vacancy", min_vac, lo);
    min_vac = rcv_vacancy_o;
  endtask

  // last queued message offered but refused
  task automatic stall_vacancy(input word_t vac);
    @(negedge clk_i);
    while (msg_in_q.size() != 0 || !(mcl_v_i && !mcl_r_o)) @(negedge clk_i);
    compare_value("rcv_vacancy at link stall", rcv_vacancy_o, vac);
  endtask

  // ----------------------------------------------------------------------
  // link model and monitors
  // ----------------------------------------------------------------------
  always @(negedge clk_i) begin
    link_take = mcl_v_i & mcl_r_o;
    // outgoing handshake lands on the coming edge
    if (!rst_i && mcl_v_o && mcl_r_i) begin
      msg_out_q.push_back(mcl_data_o);
    end
  end

  always @(posedge clk_i) begin
    // one LFSR step per ready bit
    lfsr = lfsr_next(lfsr);
    mcl_r_i <= lfsr[0];
    if (rst_i) begin
      mcl_v_i <= 1'b0;
    end else if (!mcl_v_i || link_take) begin
      if (msg_in_q.size() > 0) begin
        mcl_data_i <= msg_in_q.pop_front();
        mcl_v_i    <= 1'b1;
      end else begin
        mcl_v_i <= 1'b0;
      end
    end
    if (!rst_i && rcv_vacancy_o < min_vac) begin
      min_vac = rcv_vacancy_o;
    end
  end

  // run limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, stuck on stimulus line: %s", cycle_limit, step_note);
      $display("checks %0d, errors %0d", checks, errors + 1);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    int         fd;
    string      line;
    logic [7:0] op;
    word_t      a0;
    word_t      a1;
    word_t      a2;
    word_t      a3;

    clk_i            = 1'b0;
    rst_i            = 1'b1;
    s_axil_awaddr_i  = '0;
    s_axil_awvalid_i = 1'b0;
    s_axil_wdata_i   = '0;
    s_axil_wvalid_i  = 1'b0;
    s_axil_bready_i  = 1'b0;
    s_axil_araddr_i  = '0;
    s_axil_arvalid_i = 1'b0;
    s_axil_rready_i  = 1'b0;
    mcl_v_i          = 1'b0;
    mcl_data_i       = '0;
    mcl_r_i          = 1'b0;
    lfsr             = 32'h6f4a;
    min_vac          = vac_t'(fifo_els_lp);
    step_note        = "reset";

    // stimulus lines without comments and blanks
    fd = $fopen("sim/mcl_axil_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stimulus file sim/mcl_axil_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    cycle_limit = 200 * (lines.size() + 1);

    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    // handshakes idle and link input open
    compare_value("outputs after reset",
                  {s_axil_awready_o, s_axil_wready_o, s_axil_bvalid_o, s_axil_arready_o,
                   s_axil_rvalid_o, mcl_v_o, mcl_r_o}, 7'b000_0001);

    foreach (lines[i]) begin
      step_note = lines[i];
      void'($sscanf(lines[i], "%c %h %h %h %h", op, a0, a1, a2, a3));
      case (op)
        "W": write_reg(a0, a1, axil_resp_t'(a2));
        "R": read_reg(a0, a1, axil_resp_t'(a2));
        "M": queue_msg({a3, a2, a1, a0});
        "T": expect_msg({a3, a2, a1, a0});
        "V": settled_vacancy(a0, a1);
        "F": stall_vacancy(a0);
        "B": inject_burst(a0, a1);
        "D": drain_burst(a0, a1);
        default: begin
          errors++;
          $display("unknown command in stimulus line: %s", lines[i]);
        end
      endcase
    end

    // nothing left on the link that no T line asked for
    checks++;
    assert (msg_out_q.size() == 0) else begin
      errors++;
      $display("%0d outgoing messages were sent but never expected", msg_out_q.size());
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: source/mcl_axil_adapter.sv
// ----------------------------------------------------------------------
// AXI-lite to message link bridge, top level
// ----------------------------------------------------------------------

module mcl_axil_adapter #(
  parameter int mcl_width_p   = 128,
  parameter int rx_fifo_els_p = 8
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // AXI-lite slave from the host shell
  input  mcl_pkg::axil_addr_t                 s_axil_awaddr_i,
  input  logic                                s_axil_awvalid_i,
  output logic                                s_axil_awready_o,
  input  mcl_pkg::word_t                      s_axil_wdata_i,
  input  logic                                s_axil_wvalid_i,
  output logic                                s_axil_wready_o,
  output mcl_pkg::axil_resp_t                 s_axil_bresp_o,
  output logic                                s_axil_bvalid_o,
  input  logic                                s_axil_bready_i,
  input  mcl_pkg::axil_addr_t                 s_axil_araddr_i,
  input  logic                                s_axil_arvalid_i,
  output logic                                s_axil_arready_o,
  output mcl_pkg::word_t                      s_axil_rdata_o,
  output mcl_pkg::axil_resp_t                 s_axil_rresp_o,
  output logic                                s_axil_rvalid_o,
  input  logic                                s_axil_rready_i,
  // message link, receive
  input  logic                                mcl_v_i,
  input  logic [mcl_width_p-1:0]              mcl_data_i,
  output logic                                mcl_r_o,
  // message link, send
  output logic                                mcl_v_o,
  output logic [mcl_width_p-1:0]              mcl_data_o,
  input  logic                                mcl_r_i,
  output logic [$clog2(rx_fifo_els_p+1)-1:0]  rcv_vacancy_o
);

  // word streams around the register slave
  word_stream_if tx_ws ();
  word_stream_if rx_ws ();

  // FIFO head to unpacker
  logic                   msg_v;
  logic [mcl_width_p-1:0] msg_data;
  logic                   msg_ready;

  mcl_axil_regs u_regs (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .awaddr_i  (s_axil_awaddr_i),
    .awvalid_i (s_axil_awvalid_i),
    .awready_o (s_axil_awready_o),
    .wdata_i   (s_axil_wdata_i),
    .wvalid_i  (s_axil_wvalid_i),
    .wready_o  (s_axil_wready_o),
    .bresp_o   (s_axil_bresp_o),
    .bvalid_o  (s_axil_bvalid_o),
    .bready_i  (s_axil_bready_i),
    .araddr_i  (s_axil_araddr_i),
    .arvalid_i (s_axil_arvalid_i),
    .arready_o (s_axil_arready_o),
    .rdata_o   (s_axil_rdata_o),
    .rresp_o   (s_axil_rresp_o),
    .rvalid_o  (s_axil_rvalid_o),
    .rready_i  (s_axil_rready_i),
    .tx_o      (tx_ws.src),
    .rx_i      (rx_ws.snk)
  );

  mcl_tx_packer #(
    .mcl_width_p (mcl_width_p)
  ) u_tx_packer (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .tx_i       (tx_ws.snk),
    .mcl_v_o    (mcl_v_o),
    .mcl_data_o (mcl_data_o),
    .mcl_r_i    (mcl_r_i)
  );

  mcl_rx_buffer #(
    .mcl_width_p   (mcl_width_p),
    .rx_fifo_els_p (rx_fifo_els_p)
  ) u_rx_buffer (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .mcl_v_i       (mcl_v_i),
    .mcl_data_i    (mcl_data_i),
    .mcl_r_o       (mcl_r_o),
    .msg_v_o       (msg_v),
    .msg_data_o    (msg_data),
    .msg_ready_i   (msg_ready),
    .rcv_vacancy_o (rcv_vacancy_o)
  );

  mcl_rx_unpacker #(
    .mcl_width_p (mcl_width_p)
  ) u_rx_unpacker (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .msg_v_i     (msg_v),
    .msg_data_i  (msg_data),
    .msg_ready_o (msg_ready),
    .rx_o        (rx_ws.src)
  );

endmodule

// File: source/mcl_axil_regs.sv
// ----------------------------------------------------------------------
// AXI-lite register slave: tx data push, rx data pop, status read
// ----------------------------------------------------------------------

module mcl_axil_regs (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // write address / data / response
  input  mcl_pkg::axil_addr_t   awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  mcl_pkg::word_t        wdata_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  output mcl_pkg::axil_resp_t   bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  // read address / data
  input  mcl_pkg::axil_addr_t   araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output mcl_pkg::word_t        rdata_o,
  output mcl_pkg::axil_resp_t   rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  // word streams
  word_stream_if.src            tx_o,
  word_stream_if.snk            rx_i
);

  import mcl_pkg::*;

  wr_state_e  wr_state_r;
  logic       aw_w_ready_r;
  logic       bvalid_r;
  axil_resp_t bresp_r;
  word_t      wdata_r;

  logic       arready_r;
  logic       rvalid_r;
  logic       rd_take;
  word_t      rdata_r;
  axil_resp_t rresp_r;
  word_t      rd_data_n;
  axil_resp_t rd_resp_n;
  word_t      status_w;

  // ----------------------------------------------------------------------
  // write channel
  // ----------------------------------------------------------------------

  // aw and w are always taken together in one pulse
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_state_r   <= WR_IDLE;
      aw_w_ready_r <= 1'b0;
      bvalid_r     <= 1'b0;
    end else begin
      case (wr_state_r)
        WR_IDLE: begin
          if (awvalid_i && wvalid_i) begin
            if (awaddr_i == REG_TX_DATA) begin
              wr_state_r <= WR_WAIT_TX;
            end else begin
              // unmapped or read-only target, answer right away
              aw_w_ready_r <= 1'b1;
              wr_state_r   <= WR_RESP;
            end
          end
        end
        WR_WAIT_TX: begin
          // packer back-pressure holds the host here
          if (tx_o.ready) begin
            aw_w_ready_r <= 1'b1;
            wr_state_r   <= WR_RESP;
          end
        end
        WR_RESP: begin
          aw_w_ready_r <= 1'b0;
          // bvalid one cycle after the ready pulse
          if (aw_w_ready_r) begin
            bvalid_r <= 1'b1;
          end else if (bvalid_r && bready_i) begin
            bvalid_r   <= 1'b0;
            wr_state_r <= WR_IDLE;
          end
        end
        default: wr_state_r <= WR_IDLE;
      endcase
    end
  end

  // response code and word captured at decode
  always_ff @(posedge clk_i) begin
    if (wr_state_r == WR_IDLE && awvalid_i && wvalid_i) begin
      bresp_r <= (awaddr_i == REG_TX_DATA) ? RESP_OKAY : RESP_SLVERR;
      wdata_r <= wdata_i;
    end
  end

  assign tx_o.v    = (wr_state_r == WR_WAIT_TX);
  assign tx_o.data = wdata_r;

  assign awready_o = aw_w_ready_r;
  assign wready_o  = aw_w_ready_r;
  assign bvalid_o  = bvalid_r;
  assign bresp_o   = bresp_r;

  // ----------------------------------------------------------------------
  // read channel
  // ----------------------------------------------------------------------

  // address accepted on the arready pulse
  assign rd_take    = arready_r & arvalid_i;
  // pop only on an accepted rx data read
  assign rx_i.ready = rd_take & (araddr_i == REG_RX_DATA);

  always_comb begin
    status_w                    = '0;
    status_w[STAT_TX_READY_BIT] = tx_o.ready;
    status_w[STAT_RX_VALID_BIT] = rx_i.v;
  end

  // read decode
  always_comb begin
    rd_data_n = '0;
    rd_resp_n = RESP_SLVERR;
    case (araddr_i)
      REG_RX_DATA: begin
        // empty pop gives zero with an error
        if (rx_i.v) begin
          rd_data_n = rx_i.data;
          rd_resp_n = RESP_OKAY;
        end
      end
      REG_STATUS: begin
        rd_data_n = status_w;
        rd_resp_n = RESP_OKAY;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      arready_r <= 1'b0;
      rvalid_r  <= 1'b0;
    end else begin
      if (arready_r) begin
        arready_r <= 1'b0;
      end else if (arvalid_i && !rvalid_r) begin
        arready_r <= 1'b1;
      end
      if (rd_take) begin
        rvalid_r <= 1'b1;
      end else if (rvalid_r && rready_i) begin
        rvalid_r <= 1'b0;
      end
    end
  end

  // held until rready
  always_ff @(posedge clk_i) begin
    if (rd_take) begin
      rdata_r <= rd_data_n;
      rresp_r <= rd_resp_n;
    end
  end

  assign arready_o = arready_r;
  assign rvalid_o  = rvalid_r;
  assign rdata_o   = rdata_r;
  assign rresp_o   = rresp_r;

endmodule

// File: source/mcl_pkg.sv
// ----------------------------------------------------------------------
// shared widths, AXI-lite response codes, register map, write FSM states
// ----------------------------------------------------------------------

package mcl_pkg;

  // host side word
  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [31:0]       axil_addr_t;
  typedef logic [1:0]        axil_resp_t;

  // AXI-lite responses in use
  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // ------------------------------------------------------------------
  // register map, byte offsets
  // ------------------------------------------------------------------
  localparam axil_addr_t REG_TX_DATA = 32'h0000_0000;
  localparam axil_addr_t REG_RX_DATA = 32'h0000_0004;
  localparam axil_addr_t REG_STATUS  = 32'h0000_0008;

  // status word bit positions
  localparam int STAT_TX_READY_BIT = 0;
  localparam int STAT_RX_VALID_BIT = 1;

  // write channel FSM
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WAIT_TX,
    WR_RESP
  } wr_state_e;

endpackage

// File: source/mcl_rx_buffer.sv
// ----------------------------------------------------------------------
// rx message FIFO on the link input, with the host credit counter
// ----------------------------------------------------------------------

module mcl_rx_buffer #(
  parameter int mcl_width_p   = 128,
  parameter int rx_fifo_els_p = 8
) (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  // link input
  input  logic                                   mcl_v_i,
  input  logic [mcl_width_p-1:0]                 mcl_data_i,
  output logic                                   mcl_r_o,
  // head of FIFO toward the unpacker
  output logic                                   msg_v_o,
  output logic [mcl_width_p-1:0]                 msg_data_o,
  input  logic                                   msg_ready_i,
  // free entries seen by the shell
  output logic [$clog2(rx_fifo_els_p+1)-1:0]     rcv_vacancy_o
);

  localparam int ptr_w_lp = (rx_fifo_els_p > 1) ? $clog2(rx_fifo_els_p) : 1;
  localparam int cnt_w_lp = $clog2(rx_fifo_els_p + 1);

  typedef logic [mcl_width_p-1:0] msg_t;
  typedef logic [ptr_w_lp-1:0]    ptr_t;
  typedef logic [cnt_w_lp-1:0]    cnt_t;

  msg_t mem_r [rx_fifo_els_p];
  ptr_t wr_ptr_r;
  ptr_t rd_ptr_r;
  cnt_t count_r;
  cnt_t credit_r;
  logic enq;
  logic deq;

  assign mcl_r_o = (count_r != cnt_t'(rx_fifo_els_p));
  assign msg_v_o = (count_r != '0);
  assign enq     = mcl_v_i & mcl_r_o;
  assign deq     = msg_v_o & msg_ready_i;

  // storage
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= mcl_data_i;
    end
  end

  assign msg_data_o = mem_r[rd_ptr_r];

  // pointers wrap at depth, depth need not be a power of two
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= (wr_ptr_r == ptr_t'(rx_fifo_els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= (rd_ptr_r == ptr_t'(rx_fifo_els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      if (enq && !deq) begin
        count_r <= count_r + 1'b1;
      end else if (deq && !enq) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // credits: start full, down on enqueue, up on hand-off
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_r <= cnt_t'(rx_fifo_els_p);
    end else if (enq && !deq) begin
      credit_r <= credit_r - 1'b1;
    end else if (deq && !enq) begin
      credit_r <= credit_r + 1'b1;
    end
  end

  assign rcv_vacancy_o = credit_r;

endmodule

// File: source/mcl_rx_unpacker.sv
// ----------------------------------------------------------------------
// rx unpacker: wide message out as 32-bit words, lowest first
// ----------------------------------------------------------------------

module mcl_rx_unpacker #(
  parameter int mcl_width_p = 128
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   msg_v_i,
  input  logic [mcl_width_p-1:0] msg_data_i,
  output logic                   msg_ready_o,
  word_stream_if.src             rx_o
);

  import mcl_pkg::*;

  localparam int words_lp = mcl_width_p / WORD_W;
  localparam int idx_w_lp = (words_lp > 1) ? $clog2(words_lp) : 1;

  typedef logic [mcl_width_p-1:0] msg_t;
  typedef logic [idx_w_lp-1:0]    idx_t;

  msg_t msg_r;
  idx_t idx_r;
  logic full_r;
  logic msg_take;
  logic word_take;

  // one message held at a time
  assign msg_ready_o = ~full_r;
  assign msg_take    = msg_v_i & msg_ready_o;
  assign word_take   = rx_o.v & rx_o.ready;

  // load, then shift down a word per pop
  always_ff @(posedge clk_i) begin
    if (msg_take) begin
      msg_r <= msg_data_i;
    end else if (word_take) begin
      msg_r <= msg_r >> WORD_W;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_r <= 1'b0;
      idx_r  <= '0;
    end else if (msg_take) begin
      full_r <= 1'b1;
      idx_r  <= '0;
    end else if (word_take) begin
      if (idx_r == idx_t'(words_lp - 1)) begin
        // last word gone, free for next message
        full_r <= 1'b0;
        idx_r  <= '0;
      end else begin
        idx_r <= idx_r + 1'b1;
      end
    end
  end

  assign rx_o.v    = full_r;
  assign rx_o.data = msg_r[WORD_W-1:0];

endmodule

// File: source/mcl_tx_packer.sv
// ----------------------------------------------------------------------
// tx packer: 32-bit host words into one wide link message
// ----------------------------------------------------------------------

module mcl_tx_packer #(
  parameter int mcl_width_p = 128
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  word_stream_if.snk             tx_i,
  output logic                   mcl_v_o,
  output logic [mcl_width_p-1:0] mcl_data_o,
  input  logic                   mcl_r_i
);

  import mcl_pkg::*;

  localparam int words_lp = mcl_width_p / WORD_W;
  localparam int cnt_w_lp = (words_lp > 1) ? $clog2(words_lp) : 1;

  typedef logic [mcl_width_p-1:0] msg_t;
  typedef logic [cnt_w_lp-1:0]    cnt_t;

  msg_t msg_r;
  cnt_t cnt_r;
  logic msg_v_r;
  logic word_take;

  // stall the word stream while a full message waits
  assign tx_i.ready = ~msg_v_r;
  assign word_take  = tx_i.v & tx_i.ready;

  // fill from the bottom, first word lowest
  always_ff @(posedge clk_i) begin
    if (word_take) begin
      msg_r[cnt_r*WORD_W +: WORD_W] <= tx_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_r   <= '0;
      msg_v_r <= 1'b0;
    end else begin
      if (word_take) begin
        if (cnt_r == cnt_t'(words_lp - 1)) begin
          // group complete, offer next cycle
          cnt_r   <= '0;
          msg_v_r <= 1'b1;
        end else begin
          cnt_r <= cnt_r + 1'b1;
        end
      end else if (msg_v_r && mcl_r_i) begin
        msg_v_r <= 1'b0;
      end
    end
  end

  assign mcl_v_o    = msg_v_r;
  assign mcl_data_o = msg_r;

endmodule

// File: source/word_stream_if.sv
// ----------------------------------------------------------------------
// 32-bit word stream with valid/ready between register slave and datapath
// ----------------------------------------------------------------------

interface word_stream_if;

  import mcl_pkg::*;

  // word offered by the source
  logic  v;
  word_t data;

  // sink can take the word this cycle
  logic  ready;

  // a word moves when v and ready are both high
  // v stays up with stable data until the word is taken

  // producer side
  modport src (
    output v,
    output data,
    input  ready
  );

  // consumer side
  modport snk (
    input  v,
    input  data,
    output ready
  );

endinterface
